// ==== rv_core_pkg.sv ====
package rv_core_pkg;

  // Machine widths
  localparam int XLEN      = 64;
  localparam int ILEN      = 32;
  localparam int REG_IDX_W = 5;

  // First fetch after reset
  localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

  // RV64I major opcodes
  localparam logic [6:0] OPC_R      = 7'b0110011;
  localparam logic [6:0] OPC_I      = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // Group tag in the low bits of the execute info word
  localparam logic [2:0] EXU_TAG_ALU = 3'b000;
  localparam logic [2:0] EXU_TAG_BJP = 3'b001;

  // ALU view, one-hot op select
  typedef struct packed {
    logic       ebreak;
    logic       lui;
    logic       op_and;
    logic       op_or;
    logic       sra;
    logic       srl;
    logic       op_xor;
    logic       sltu;
    logic       slt;
    logic       sll;
    logic       sub;
    logic       add;
    logic [2:0] tag;
  } alu_info_t;

  // Branch/jump view, spare bits stay zero
  typedef struct packed {
    logic [3:0] spare;
    logic       bgeu;
    logic       bltu;
    logic       bge;
    logic       blt;
    logic       bne;
    logic       beq;
    logic       jalr;
    logic       jal;
    logic [2:0] tag;
  } bjp_info_t;

  // Same 15 bits read either way, tag picks the view
  typedef union packed {
    alu_info_t alu;
    bjp_info_t bjp;
  } exu_info_u;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [ILEN-1:0] inst;
  } fetch_t;

  // Decode result for execute and commit
  typedef struct packed {
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      op1;
    logic [XLEN-1:0]      op2;
    logic [XLEN-1:0]      op1_jp;
    logic [XLEN-1:0]      op2_jp;
    logic [REG_IDX_W-1:0] rd_idx;
    logic                 rd_wr_en;
    logic                 invalid;
    exu_info_u            info;
  } dec_t;

  // Retire record
  typedef struct packed {
    logic                 valid;
    logic [XLEN-1:0]      pc;
    logic [REG_IDX_W-1:0] rd_idx;
    logic                 rd_wr_en;
    logic [XLEN-1:0]      rd_data;
  } commit_t;

endpackage

// ==== ifu_pc.sv ====
`timescale 1ns/1ps

module ifu_pc
  import rv_core_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic [ILEN-1:0] inst_i,
  input  logic [XLEN-1:0] next_pc_i,
  input  logic            halt_i,
  output logic [XLEN-1:0] pc_o,
  output fetch_t          fetch_o
);

  logic [XLEN-1:0] pc_q;

  // One instruction per clock, frozen for good once halted
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= RESET_PC;
    end else if (!halt_i) begin
      pc_q <= next_pc_i;
    end
  end

  // Fetch address out
  assign pc_o = pc_q;

  // Instruction comes back in the same cycle
  assign fetch_o.pc   = pc_q;
  assign fetch_o.inst = inst_i;

  // Branch and jump targets from execute must keep word alignment
  a_pc_aligned: assert property (
    @(posedge clk_i) disable iff (rst_i)
    pc_q[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", pc_q);

endmodule

// ==== idu.sv ====
`timescale 1ns/1ps

module idu
  import rv_core_pkg::*;
(
  input  fetch_t               fetch_i,
  input  logic [XLEN-1:0]      rs1_data_i,
  input  logic [XLEN-1:0]      rs2_data_i,
  output logic [REG_IDX_W-1:0] rs1_idx_o,
  output logic [REG_IDX_W-1:0] rs2_idx_o,
  output dec_t                 dec_o
);

  logic [ILEN-1:0]      inst;
  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [REG_IDX_W-1:0] rd;
  logic [XLEN-1:0]      imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  logic is_r, is_i, is_l, is_s, is_b, is_jal, is_jalr, is_lui, is_auipc, is_sys;
  logic f7_base, f7_alt, sh_base, sh_alt;
  logic jalr, ebreak, alu_op, bjp_op, invalid;
  logic rs1_need, rs2_need;
  exu_info_u info;

  // Field extraction
  assign inst      = fetch_i.inst;
  assign opcode    = inst[6:0];
  assign rd        = inst[11:7];
  assign funct3    = inst[14:12];
  assign rs1_idx_o = inst[19:15];
  assign rs2_idx_o = inst[24:20];

  // Immediates, all sign extended
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // Major opcode classes
  assign is_r     = (opcode == OPC_R);
  assign is_i     = (opcode == OPC_I);
  assign is_l     = (opcode == OPC_LOAD);
  assign is_s     = (opcode == OPC_STORE);
  assign is_b     = (opcode == OPC_BRANCH);
  assign is_jal   = (opcode == OPC_JAL);
  assign is_jalr  = (opcode == OPC_JALR);
  assign is_lui   = (opcode == OPC_LUI);
  assign is_auipc = (opcode == OPC_AUIPC);
  assign is_sys   = (opcode == OPC_SYSTEM);

  // funct7 for R ops; 6-bit shamt in RV64 leaves imm[11:6] for I shifts
  assign f7_base = (inst[31:25] == 7'h00);
  assign f7_alt  = (inst[31:25] == 7'h20);
  assign sh_base = (inst[31:26] == 6'h00);
  assign sh_alt  = (inst[31:26] == 6'h10);

  assign jalr    = is_jalr & (funct3 == 3'd0);
  assign ebreak  = is_sys & (funct3 == 3'd0) & (inst[31:20] == 12'h001);
  assign alu_op  = is_r | is_i | is_lui | is_auipc | ebreak;
  assign bjp_op  = is_b | is_jal | jalr;
  // Loads and stores count as valid even without data memory
  assign invalid = ~(is_r | is_i | is_l | is_s | is_b | is_jal | is_jalr |
                     is_lui | is_auipc | is_sys);

  // Register read demand
  assign rs1_need = is_r | is_i | is_l | is_s | is_b | is_jalr;
  assign rs2_need = is_r | is_s | is_b;

  assign imm = ({XLEN{is_i | is_l | jalr}} & imm_i) |
               ({XLEN{is_s}}               & imm_s) |
               ({XLEN{is_b}}               & imm_b) |
               ({XLEN{is_jal}}             & imm_j) |
               ({XLEN{is_lui | is_auipc}}  & imm_u);

  // op1 is rs1 or pc; LUI leaves it zero
  assign dec_o.op1 = ({XLEN{rs1_need & ~is_jalr}}     & rs1_data_i) |
                     ({XLEN{is_auipc | is_jal | jalr}} & fetch_i.pc);
  // op2 is rs2, imm or 4 for the link value
  assign dec_o.op2 = ({XLEN{rs2_need & ~is_s}} & rs2_data_i) |
                     ({XLEN{is_i | is_l | is_s | is_auipc | is_lui}} & imm) |
                     ({XLEN{is_jal | jalr}} & 64'd4);
  // Target pair, rs1+imm for JALR, pc+imm otherwise
  assign dec_o.op1_jp = ({XLEN{jalr}}          & rs1_data_i) |
                        ({XLEN{is_b | is_jal}} & fetch_i.pc);
  assign dec_o.op2_jp = {XLEN{bjp_op}} & imm;

  // Execute info, ALU view or BJP view, zero when nothing selected
  always_comb begin
    info = '0;
    if (alu_op) begin
      info.alu.tag    = EXU_TAG_ALU;
      info.alu.add    = (is_r & (funct3 == 3'd0) & f7_base) | (is_i & (funct3 == 3'd0)) |
                        is_auipc;
      info.alu.sub    = is_r & (funct3 == 3'd0) & f7_alt;
      info.alu.sll    = (is_r & (funct3 == 3'd1) & f7_base) | (is_i & (funct3 == 3'd1) & sh_base);
      info.alu.slt    = (is_r & f7_base | is_i) & (funct3 == 3'd2);
      info.alu.sltu   = (is_r & f7_base | is_i) & (funct3 == 3'd3);
      info.alu.op_xor = (is_r & f7_base | is_i) & (funct3 == 3'd4);
      info.alu.srl    = (is_r & (funct3 == 3'd5) & f7_base) | (is_i & (funct3 == 3'd5) & sh_base);
      info.alu.sra    = (is_r & (funct3 == 3'd5) & f7_alt) | (is_i & (funct3 == 3'd5) & sh_alt);
      info.alu.op_or  = (is_r & f7_base | is_i) & (funct3 == 3'd6);
      info.alu.op_and = (is_r & f7_base | is_i) & (funct3 == 3'd7);
      info.alu.lui    = is_lui;
      info.alu.ebreak = ebreak;
    end else if (bjp_op) begin
      info.bjp.tag  = EXU_TAG_BJP;
      info.bjp.jal  = is_jal;
      info.bjp.jalr = jalr;
      info.bjp.beq  = is_b & (funct3 == 3'd0);
      info.bjp.bne  = is_b & (funct3 == 3'd1);
      info.bjp.blt  = is_b & (funct3 == 3'd4);
      info.bjp.bge  = is_b & (funct3 == 3'd5);
      info.bjp.bltu = is_b & (funct3 == 3'd6);
      info.bjp.bgeu = is_b & (funct3 == 3'd7);
    end
  end

  assign dec_o.pc     = fetch_i.pc;
  assign dec_o.rd_idx = rd;
  // No write for x0, stores, branches, loads, ebreak; invalid too
  assign dec_o.rd_wr_en = (rd != '0) & ~(is_s | is_b | is_l | ebreak | invalid);
  assign dec_o.invalid  = invalid;
  assign dec_o.info     = info;

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile
  import rv_core_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [REG_IDX_W-1:0] rs1_idx_i,
  input  logic [REG_IDX_W-1:0] rs2_idx_i,
  input  logic [REG_IDX_W-1:0] wr_idx_i,
  input  logic                 wr_en_i,
  input  logic [XLEN-1:0]      wr_data_i,
  output logic [XLEN-1:0]      rs1_data_o,
  output logic [XLEN-1:0]      rs2_data_o
);

  // x1..x31 only, x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && (wr_idx_i != '0)) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // Async reads, x0 reads as zero
  // written value visible next cycle, no bypass
  assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

  // Decode must already have dropped rd_wr_en for rd = x0
  a_no_x0_write: assert property (
    @(posedge clk_i) disable iff (rst_i)
    wr_en_i |-> (wr_idx_i != '0)
  ) else $error("write enable raised for x0");

endmodule

// ==== exu.sv ====
`timescale 1ns/1ps

module exu
  import rv_core_pkg::*;
(
  input  dec_t            dec_i,
  output logic [XLEN-1:0] wb_data_o,
  output logic [XLEN-1:0] next_pc_o,
  output logic            ebreak_o
);

  alu_info_t       alu;
  bjp_info_t       bjp;
  logic            is_alu, is_bjp;
  logic [XLEN-1:0] op1, op2;
  logic [5:0]      shamt;
  logic [XLEN-1:0] alu_res, sra_res, pc_plus4, jp_target;
  logic            eq, lt, ltu, br_taken, jump;

  // Two views of the same info word
  assign alu    = dec_i.info.alu;
  assign bjp    = dec_i.info.bjp;
  assign is_alu = (alu.tag == EXU_TAG_ALU);
  assign is_bjp = (bjp.tag == EXU_TAG_BJP);

  assign op1   = dec_i.op1;
  assign op2   = dec_i.op2;
  // RV64 shifts use 6 bits
  assign shamt = op2[5:0];

  // Arithmetic right shift fills with the sign of op1
  assign sra_res = $signed(op1) >>> shamt;

  // One-hot mux that gives zero when no bit is set
  assign alu_res =
    ({XLEN{alu.add}}    & (op1 + op2)) |
    ({XLEN{alu.sub}}    & (op1 - op2)) |
    ({XLEN{alu.sll}}    & (op1 << shamt)) |
    ({XLEN{alu.slt}}    & {{(XLEN-1){1'b0}}, lt}) |
    ({XLEN{alu.sltu}}   & {{(XLEN-1){1'b0}}, ltu}) |
    ({XLEN{alu.op_xor}} & (op1 ^ op2)) |
    ({XLEN{alu.srl}}    & (op1 >> shamt)) |
    ({XLEN{alu.sra}}    & sra_res) |
    ({XLEN{alu.op_or}}  & (op1 | op2)) |
    ({XLEN{alu.op_and}} & (op1 & op2)) |
    ({XLEN{alu.lui}}    & op2);

  // Comparator shared by slt and branches
  assign eq  = (op1 == op2);
  assign lt  = ($signed(op1) < $signed(op2));
  assign ltu = (op1 < op2);

  assign jump     = is_bjp & (bjp.jal | bjp.jalr);
  assign br_taken = is_bjp & ((bjp.beq  &  eq)  | (bjp.bne  & ~eq) |
                              (bjp.blt  &  lt)  | (bjp.bge  & ~lt) |
                              (bjp.bltu &  ltu) | (bjp.bgeu & ~ltu));

  assign pc_plus4  = dec_i.pc + 64'd4;
  assign jp_target = dec_i.op1_jp + dec_i.op2_jp;

  // Jumps link op1+op2, which decode set up as pc+4
  assign wb_data_o = is_alu ? alu_res :
                     jump   ? (op1 + op2) : '0;

  // JALR drops bit 0 of the target
  always_comb begin
    next_pc_o = pc_plus4;
    if (jump && bjp.jalr) begin
      next_pc_o = {jp_target[XLEN-1:1], 1'b0};
    end else if (jump || br_taken) begin
      next_pc_o = jp_target;
    end
  end

  assign ebreak_o = is_alu & alu.ebreak;

  // Decode output has a known tag and at most one op bit in either view
  a_info_onehot: assert final (
    $onehot0(dec_i.info[14:3]) && (is_alu || is_bjp)
  ) else $error("bad execute info word: %h", dec_i.info);

endmodule

// ==== commit_unit.sv ====
`timescale 1ns/1ps

module commit_unit
  import rv_core_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  dec_t                 dec_i,
  input  logic [XLEN-1:0]      wb_data_i,
  input  logic                 ebreak_i,
  output logic                 wr_en_o,
  output logic [REG_IDX_W-1:0] wr_idx_o,
  output logic [XLEN-1:0]      wr_data_o,
  output commit_t              commit_o,
  output logic                 halt_o
);

  logic                 halt_q, valid_q, rd_wr_en_q;
  logic [XLEN-1:0]      pc_q, rd_data_q;
  logic [REG_IDX_W-1:0] rd_idx_q;

  // Write lands at the edge ending the instruction, nothing after halt
  assign wr_en_o   = dec_i.rd_wr_en & ~halt_q;
  assign wr_idx_o  = dec_i.rd_idx;
  assign wr_data_o = wb_data_i;

  // Halting instruction still commits, then valid stays low
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      halt_q  <= 1'b0;
    end else begin
      valid_q <= ~halt_q;
      halt_q  <= halt_q | ebreak_i | dec_i.invalid;
    end
  end

  // Retire payload
  always_ff @(posedge clk_i) begin
    pc_q       <= dec_i.pc;
    rd_idx_q   <= dec_i.rd_idx;
    rd_wr_en_q <= wr_en_o;
    rd_data_q  <= wb_data_i;
  end

  assign commit_o.valid    = valid_q;
  assign commit_o.pc       = pc_q;
  assign commit_o.rd_idx   = rd_idx_q;
  assign commit_o.rd_wr_en = rd_wr_en_q;
  assign commit_o.rd_data  = rd_data_q;
  assign halt_o            = halt_q;

endmodule

// ==== rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top
  import rv_core_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic [ILEN-1:0] inst_i,
  output logic [XLEN-1:0] pc_o,
  output commit_t         commit_o,
  output logic            halt_o
);

  fetch_t               fetch;
  dec_t                 dec;
  logic [REG_IDX_W-1:0] rs1_idx, rs2_idx, wr_idx;
  logic [XLEN-1:0]      rs1_data, rs2_data, wr_data;
  logic [XLEN-1:0]      wb_data, next_pc;
  logic                 ebreak, wr_en;

  // Fetch, halt level holds the pc
  ifu_pc i_ifu_pc (.clk_i, .rst_i, .inst_i, .next_pc_i(next_pc), .halt_i(halt_o), .pc_o,
                   .fetch_o(fetch));

  // Decode with combinational register reads
  idu i_idu (.fetch_i(fetch), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
             .rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx), .dec_o(dec));

  regfile i_regfile (.clk_i, .rst_i, .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx),
                     .wr_idx_i(wr_idx), .wr_en_i(wr_en), .wr_data_i(wr_data),
                     .rs1_data_o(rs1_data), .rs2_data_o(rs2_data));

  exu i_exu (.dec_i(dec), .wb_data_o(wb_data), .next_pc_o(next_pc), .ebreak_o(ebreak));

  // Write port driven from commit
  commit_unit i_commit_unit (.clk_i, .rst_i, .dec_i(dec), .wb_data_i(wb_data),
                             .ebreak_i(ebreak), .wr_en_o(wr_en), .wr_idx_o(wr_idx),
                             .wr_data_o(wr_data), .commit_o, .halt_o);

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core
  import rv_core_pkg::*;
();

  localparam int              PROG_DEPTH  = 64;
  localparam int              RUN_TIMEOUT = 200;
  localparam int              HALT_WINDOW = 12;
  localparam logic [ILEN-1:0] INST_EBREAK = 32'h0010_0073;

  logic            clk_i;
  logic            rst_i;
  logic [ILEN-1:0] inst_i;
  logic [XLEN-1:0] pc_o;
  commit_t         commit_o;
  logic            halt_o;

  logic [ILEN-1:0] prog [0:PROG_DEPTH-1];
  int              prog_len = 0;
  logic [XLEN-1:0] fetch_idx;
  logic [XLEN-1:0] model_x [0:31];
  commit_t         exp_q [$];
  int              seed;
  string           test_name;
  int              errors, test_errors, tests_run, tests_failed;

  rv_core_top i_rv_core_top (.clk_i, .rst_i, .inst_i, .pc_o, .commit_o, .halt_o);

  always #20 clk_i = ~clk_i;

  // Program memory answers the fetch address with EBREAK past the end
  assign fetch_idx = (pc_o - RESET_PC) >> 2;
  assign inst_i    = ((fetch_idx < prog_len) === 1'b1) ? prog[fetch_idx[5:0]] : INST_EBREAK;

  // Instruction encoders
  function automatic logic [ILEN-1:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_R};
  endfunction

  function automatic logic [ILEN-1:0] i_type(input logic [6:0] opc, input logic [31:0] imm,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic logic [ILEN-1:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [ILEN-1:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [ILEN-1:0] u_type(input logic [6:0] opc, input logic [31:0] imm,
                                             input logic [4:0] rd);
    return {imm[19:0], rd, opc};
  endfunction

  function automatic logic [ILEN-1:0] j_type(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [ILEN-1:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [31:0] imm);
    return i_type(OPC_I, imm, rs1, 3'd0, rd);
  endfunction

  function automatic logic [ILEN-1:0] program_word(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] idx;
    idx = (addr - RESET_PC) >> 2;
    return (idx < prog_len) ? prog[idx[5:0]] : INST_EBREAK;
  endfunction

  // Reference ALU from the RV64I rules with funct3 as select
  function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    sa = a;
    case (f3)
      3'd0: return alt ? (a - b) : (a + b);
      3'd1: return a << b[5:0];
      3'd2: return {63'd0, $signed(a) < $signed(b)};
      3'd3: return {63'd0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          sa = sa >>> b[5:0];
          return sa;
        end
        return a >> b[5:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Runs the loaded program on the model with one expected record per retire
  task automatic model_program();
    logic [XLEN-1:0] pc, a, b, res, nxt, imm_i;
    logic [ILEN-1:0] inst;
    logic [2:0]      f3;
    logic            we, stop;
    commit_t         rec;
    pc   = RESET_PC;
    stop = 1'b0;
    exp_q.delete();
    for (int r = 0; r < 32; r++) begin
      model_x[r] = '0;
    end
    for (int step = 0; step < RUN_TIMEOUT && !stop; step++) begin
      inst  = program_word(pc);
      a     = model_x[inst[19:15]];
      b     = model_x[inst[24:20]];
      f3    = inst[14:12];
      imm_i = {{52{inst[31]}}, inst[31:20]};
      res   = '0;
      we    = 1'b0;
      nxt   = pc + 64'd4;
      case (inst[6:0])
        OPC_R: begin
          res = alu_ref(f3, inst[30], a, b);
          we  = 1'b1;
        end
        // Bit 30 only picks srai and elsewhere belongs to the immediate
        OPC_I: begin
          res = alu_ref(f3, (f3 == 3'd5) && inst[30], a, imm_i);
          we  = 1'b1;
        end
        OPC_LUI: begin
          res = {{32{inst[31]}}, inst[31:12], 12'd0};
          we  = 1'b1;
        end
        OPC_AUIPC: begin
          res = pc + {{32{inst[31]}}, inst[31:12], 12'd0};
          we  = 1'b1;
        end
        OPC_JAL: begin
          res = pc + 64'd4;
          we  = 1'b1;
          nxt = pc + {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        OPC_JALR: begin
          res = pc + 64'd4;
          we  = 1'b1;
          nxt = (a + imm_i) & ~64'd1;
        end
        OPC_BRANCH: begin
          if (branch_taken(f3, a, b)) begin
            nxt = pc + {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
          end
        end
        // No data memory so they retire without a write
        OPC_LOAD, OPC_STORE: ;
        // Only EBREAK is used from SYSTEM so this is EBREAK or an invalid word
        default: stop = 1'b1;
      endcase
      rec.valid    = 1'b1;
      rec.pc       = pc;
      rec.rd_idx   = inst[11:7];
      rec.rd_wr_en = we && (inst[11:7] != 5'd0);
      rec.rd_data  = res;
      if (rec.rd_wr_en) begin
        model_x[inst[11:7]] = res;
      end
      exp_q.push_back(rec);
      pc = nxt;
    end
  endtask

  function automatic string commit_str(input commit_t c);
    return $sformatf("pc %h rd x%0d we %b data %h", c.pc, c.rd_idx, c.rd_wr_en, c.rd_data);
  endfunction

  task automatic check_word(input string what, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_commit(input commit_t exp, input commit_t act);
    // rd_data carries no result when nothing is written
    if (!exp.rd_wr_en) begin
      act.rd_data = exp.rd_data;
    end
    if (act !== exp) begin
      $display("Mismatch %s commit: expected %s, actual %s", test_name,
               commit_str(exp), commit_str(act));
      test_errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_i <= 1'b1;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    prog_len    = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("%s: %s, %0d error(s)", test_name, (test_errors == 0) ? "ok" : "failed",
             test_errors);
  endtask

  task automatic put(input logic [ILEN-1:0] inst);
    prog[prog_len] = inst;
    prog_len++;
  endtask

  // Model, reset, collect retires until halt, compare, then watch the halted core
  task automatic run_program();
    commit_t         got_q [$];
    logic [XLEN-1:0] frozen_pc;
    int              cycles;
    model_program();
    apply_reset();
    cycles = 0;
    while (!halt_o && cycles < RUN_TIMEOUT) begin
      @(negedge clk_i);
      if (commit_o.valid) begin
        got_q.push_back(commit_o);
      end
      cycles++;
    end
    if (!halt_o) begin
      $display("%s: timeout, core did not halt within %0d cycles", test_name, RUN_TIMEOUT);
      test_errors++;
    end
    check_word("commit count", exp_q.size(), got_q.size());
    foreach (exp_q[i]) begin
      if (i < got_q.size()) begin
        check_commit(exp_q[i], got_q[i]);
      end
    end
    if (halt_o) begin
      frozen_pc = pc_o;
      repeat (HALT_WINDOW) begin
        @(negedge clk_i);
        check_word("halt_o", 64'd1, {63'd0, halt_o});
        check_word("pc_o after halt", frozen_pc, pc_o);
        check_word("commit valid after halt", 64'd0, {63'd0, commit_o.valid});
      end
    end
  endtask

  task automatic reset_check();
    start_test("reset");
    apply_reset();
    @(negedge clk_i);
    check_word("pc_o", RESET_PC, pc_o);
    check_word("commit valid", 64'd0, {63'd0, commit_o.valid});
    check_word("halt_o", 64'd0, {63'd0, halt_o});
    finish_test();
  endtask

  task automatic alu_ops();
    logic [31:0] r;
    start_test("alu");
    // x1 negative so the arithmetic shifts fill with ones
    put(u_type(OPC_LUI, $random(seed) | 32'h8_0000, 5'd1));
    put(addi(5'd1, 5'd1, $random(seed)));
    put(u_type(OPC_AUIPC, $random(seed), 5'd2));
    put(addi(5'd3, 5'd0, $random(seed)));
    // Register forms x4..x11 then sub and sra
    for (int k = 0; k < 8; k++) begin
      put(r_type(7'h00, 5'd3, 5'd1, k[2:0], 5'(4 + k)));
    end
    put(r_type(7'h20, 5'd3, 5'd1, 3'd0, 5'd12));
    put(r_type(7'h20, 5'd3, 5'd1, 3'd5, 5'd13));
    // Immediate forms x14..x21 with shifts keeping imm[11:6] clear
    for (int k = 0; k < 8; k++) begin
      r = $random(seed);
      if (k == 1 || k == 5) begin
        r = r & 32'h3F;
      end
      put(i_type(OPC_I, r, 5'd2, k[2:0], 5'(14 + k)));
    end
    r = $random(seed);
    put(i_type(OPC_I, 32'h400 | (r & 32'h3F), 5'd1, 3'd5, 5'd22));
    put(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
    put(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd23));
    put(INST_EBREAK);
    run_program();
    finish_test();
  endtask

  task automatic branches();
    logic [2:0] kinds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [4:0] lhs [3]   = '{5'd1, 5'd2, 5'd1};
    logic [4:0] rhs [3]   = '{5'd2, 5'd1, 5'd1};
    start_test("branch");
    // x1 negative and x2 non-negative so each kind goes both ways
    put(addi(5'd1, 5'd0, $random(seed) | 32'h800));
    put(addi(5'd2, 5'd0, $random(seed) & 32'h7FF));
    foreach (kinds[k]) begin
      for (int p = 0; p < 3; p++) begin
        put(b_type(32'd8, rhs[p], lhs[p], kinds[k]));
        put(addi(5'd7, 5'd7, 32'd1));
      end
    end
    put(INST_EBREAK);
    run_program();
    finish_test();
  endtask

  task automatic jumps();
    start_test("jump");
    put(u_type(OPC_AUIPC, 32'd0, 5'd3));
    put(j_type(32'd12, 5'd1));
    put(addi(5'd5, 5'd5, 32'd1));
    put(addi(5'd5, 5'd5, 32'd1));
    // Odd target base+29 lands on base+28
    put(addi(5'd4, 5'd3, 32'd29));
    put(i_type(OPC_JALR, 32'd0, 5'd4, 3'd0, 5'd2));
    put(addi(5'd5, 5'd5, 32'd1));
    put(j_type(32'd8, 5'd0));
    put(addi(5'd5, 5'd5, 32'd1));
    put(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd6));
    put(INST_EBREAK);
    run_program();
    finish_test();
  endtask

  task automatic loads_stores();
    start_test("load_store");
    put(addi(5'd1, 5'd0, $random(seed)));
    put(i_type(OPC_LOAD, 32'd8, 5'd0, 3'd3, 5'd2));
    put(s_type($random(seed), 5'd1, 5'd0, 3'd3));
    put(i_type(OPC_LOAD, 32'd0, 5'd1, 3'd2, 5'd3));
    put(addi(5'd4, 5'd2, 32'd1));
    put(r_type(7'h00, 5'd1, 5'd3, 3'd0, 5'd5));
    put(INST_EBREAK);
    run_program();
    finish_test();
  endtask

  task automatic halt_on_ebreak();
    start_test("halt_ebreak");
    put(addi(5'd1, 5'd0, 32'd5));
    put(INST_EBREAK);
    put(addi(5'd1, 5'd1, 32'd1));
    put(addi(5'd2, 5'd0, 32'd7));
    run_program();
    finish_test();
  endtask

  task automatic halt_on_invalid();
    start_test("halt_invalid");
    put(addi(5'd1, 5'd0, 32'd9));
    // custom-0 opcode with rd = x31
    put(32'h0000_0F8B);
    put(addi(5'd1, 5'd1, 32'd1));
    run_program();
    finish_test();
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    seed         = 32'he01c10e0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset_check();
    alu_ops();
    branches();
    jumps();
    loads_stores();
    halt_on_ebreak();
    halt_on_invalid();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
rv_core_pkg.sv
ifu_pc.sv
idu.sv
regfile.sv
exu.sv
commit_unit.sv
rv_core_top.sv
tb_rv_core.sv
